//--- hdl/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Physical address width
`define DC_ADDR_BITS 15

// Bytes per line, low 4 address bits are the byte offset
`define DC_LINE_BYTES 16

// Index width per bank, address bits 8:5
`define DC_INDEX_BITS 4

// Request ID width
`define DC_ID_BITS 7

// Access queue entries, also the starting credit count
`define DC_AQ_DEPTH 4

`endif

//--- hdl/dcache_pkg.sv
`default_nettype none
`include "dcache_settings.svh"

package dcache_pkg;

   // Address field positions, bank select sits just above the byte offset
   localparam int BANK_BIT  = $clog2(`DC_LINE_BYTES);
   localparam int INDEX_LSB = BANK_BIT + 1;
   localparam int TAG_LSB   = INDEX_LSB + `DC_INDEX_BITS;
   localparam int TAG_BITS  = `DC_ADDR_BITS - TAG_LSB;
   localparam int LINES     = 1 << `DC_INDEX_BITS;

   typedef logic [`DC_ADDR_BITS-1:0]            paddr_t;
   typedef logic [`DC_LINE_BYTES*8-1:0]         line_t;
   typedef logic [`DC_ID_BITS-1:0]              req_id_t;
   typedef logic [`DC_INDEX_BITS-1:0]           index_t;
   typedef logic [TAG_BITS-1:0]                 tag_t;
   typedef logic [$clog2(`DC_AQ_DEPTH+1)-1:0]   credit_t;

   typedef enum logic {
      op_read,
      op_write
   } aq_op_t;

endpackage

`default_nettype wire

//--- hdl/access_steer.sv
`timescale 1ns/1ns
`default_nettype none
`include "dcache_settings.svh"

module access_steer
   import dcache_pkg::*;
(
   input  wire          clk,
   input  wire          rst_i,
   input  wire          rd_valid_i,
   input  wire paddr_t  rd_addr_i,
   input  wire req_id_t rd_id_i,
   input  wire          wb_valid_i,
   input  wire paddr_t  wb_addr_i,
   input  wire line_t   wb_line_i,
   input  wire          credit_e_i,
   input  wire          credit_o_i,
   output logic         rd_ready_o,
   output logic         wb_ready_o,
   output logic         push_e_o,
   output logic         push_o_o,
   output aq_op_t       push_op_e_o,
   output aq_op_t       push_op_o_o,
   output paddr_t       push_addr_e_o,
   output paddr_t       push_addr_o_o,
   output req_id_t      push_id_e_o,
   output req_id_t      push_id_o_o,
   output line_t        push_line_e_o,
   output line_t        push_line_o_o
);

   credit_t cred_e;
   credit_t cred_o;
   logic    rd_bank;
   logic    wb_bank;
   logic    rd_fire;
   logic    wb_fire;
   logic    wr_e;
   logic    wr_o;

   assign rd_bank = rd_addr_i[BANK_BIT];
   assign wb_bank = wb_addr_i[BANK_BIT];

   assign wb_ready_o = wb_bank ? (cred_o != '0) : (cred_e != '0);

   // Read waits when a write wants the same bank
   assign rd_ready_o = (rd_bank ? (cred_o != '0) : (cred_e != '0)) &&
                       !(wb_valid_i && (wb_bank == rd_bank));

   assign wb_fire = wb_valid_i && wb_ready_o;
   assign rd_fire = rd_valid_i && rd_ready_o;

   assign wr_e = wb_fire && !wb_bank;
   assign wr_o = wb_fire && wb_bank;

   assign push_e_o = wr_e || (rd_fire && !rd_bank);
   assign push_o_o = wr_o || (rd_fire && rd_bank);

   // Even bank fields
   assign push_op_e_o   = wr_e ? op_write : op_read;
   assign push_addr_e_o = wr_e ? wb_addr_i : rd_addr_i;
   assign push_id_e_o   = wr_e ? '0 : rd_id_i;
   assign push_line_e_o = wr_e ? wb_line_i : '0;

   // Odd bank fields
   assign push_op_o_o   = wr_o ? op_write : op_read;
   assign push_addr_o_o = wr_o ? wb_addr_i : rd_addr_i;
   assign push_id_o_o   = wr_o ? '0 : rd_id_i;
   assign push_line_o_o = wr_o ? wb_line_i : '0;

   // One queue slot per credit
   always_ff @(posedge clk) begin
      if (rst_i) begin
         cred_e <= credit_t'(`DC_AQ_DEPTH);
         cred_o <= credit_t'(`DC_AQ_DEPTH);
      end else begin
         cred_e <= cred_e + credit_t'(credit_e_i) - credit_t'(push_e_o);
         cred_o <= cred_o + credit_t'(credit_o_i) - credit_t'(push_o_o);
      end
   end

endmodule

`default_nettype wire

//--- hdl/access_queue.sv
`timescale 1ns/1ns
`default_nettype none
`include "dcache_settings.svh"

module access_queue
   import dcache_pkg::*;
(
   input  wire          clk,
   input  wire          rst_i,
   input  wire          push_i,
   input  wire aq_op_t  push_op_i,
   input  wire paddr_t  push_addr_i,
   input  wire req_id_t push_id_i,
   input  wire line_t   push_line_i,
   input  wire          pop_i,
   output logic         head_valid_o,
   output aq_op_t       head_op_o,
   output paddr_t       head_addr_o,
   output req_id_t      head_id_o,
   output line_t        head_line_o,
   output logic         credit_o
);

   localparam int PTR_BITS = $clog2(`DC_AQ_DEPTH);

   aq_op_t  op_mem   [`DC_AQ_DEPTH];
   paddr_t  addr_mem [`DC_AQ_DEPTH];
   req_id_t id_mem   [`DC_AQ_DEPTH];
   line_t   line_mem [`DC_AQ_DEPTH];

   logic [PTR_BITS-1:0] wr_ptr;
   logic [PTR_BITS-1:0] rd_ptr;
   credit_t             count;
   logic                do_pop;

   function automatic logic [PTR_BITS-1:0] ptr_inc(logic [PTR_BITS-1:0] p);
      ptr_inc = (p == PTR_BITS'(`DC_AQ_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign head_valid_o = (count != '0);
   assign do_pop       = pop_i && head_valid_o;

   assign head_op_o   = op_mem[rd_ptr];
   assign head_addr_o = addr_mem[rd_ptr];
   assign head_id_o   = id_mem[rd_ptr];
   assign head_line_o = line_mem[rd_ptr];

   // Space is guaranteed by the sender's credits
   always_ff @(posedge clk) begin
      if (push_i) begin
         op_mem[wr_ptr]   <= push_op_i;
         addr_mem[wr_ptr] <= push_addr_i;
         id_mem[wr_ptr]   <= push_id_i;
         line_mem[wr_ptr] <= push_line_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         credit_o <= 1'b0;
      end else begin
         if (push_i)
            wr_ptr <= ptr_inc(wr_ptr);
         if (do_pop)
            rd_ptr <= ptr_inc(rd_ptr);
         count    <= count + credit_t'(push_i) - credit_t'(do_pop);
         credit_o <= do_pop;
      end
   end

endmodule

`default_nettype wire

//--- hdl/cache_bank.sv
`timescale 1ns/1ns
`default_nettype none

module cache_bank
   import dcache_pkg::*;
(
   input  wire          clk,
   input  wire          rst_i,
   input  wire          head_valid_i,
   input  wire aq_op_t  head_op_i,
   input  wire paddr_t  head_addr_i,
   input  wire req_id_t head_id_i,
   input  wire line_t   head_line_i,
   input  wire          take_i,
   output logic         pop_o,
   output logic         out_valid_o,
   output req_id_t      out_id_o,
   output logic         out_hit_o,
   output line_t        out_line_o
);

   logic [LINES-1:0] valid_q;
   tag_t             tag_mem  [LINES];
   line_t            line_mem [LINES];

   index_t idx;
   tag_t   tag;
   logic   lookup_hit;
   logic   pop_rd;
   logic   pop_wr;

   assign idx = head_addr_i[INDEX_LSB +: $bits(index_t)];
   assign tag = head_addr_i[TAG_LSB +: $bits(tag_t)];

   assign lookup_hit = valid_q[idx] && (tag_mem[idx] == tag);

   // Pop only when the result slot is free or drains this cycle
   assign pop_o  = head_valid_i && (!out_valid_o || take_i);
   assign pop_rd = pop_o && (head_op_i == op_read);
   assign pop_wr = pop_o && (head_op_i == op_write);

   // Full-line install
   always_ff @(posedge clk) begin
      if (pop_wr) begin
         tag_mem[idx]  <= tag;
         line_mem[idx] <= head_line_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i)
         valid_q <= '0;
      else if (pop_wr)
         valid_q[idx] <= 1'b1;
   end

   // Result register, held until the merge takes it
   always_ff @(posedge clk) begin
      if (rst_i)
         out_valid_o <= 1'b0;
      else if (pop_rd)
         out_valid_o <= 1'b1;
      else if (take_i)
         out_valid_o <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (pop_rd) begin
         out_id_o   <= head_id_i;
         out_hit_o  <= lookup_hit;
         // Misses return zeros rather than a stale line
         out_line_o <= lookup_hit ? line_mem[idx] : '0;
      end
   end

endmodule

`default_nettype wire

//--- hdl/result_merge.sv
`timescale 1ns/1ns
`default_nettype none

module result_merge
   import dcache_pkg::*;
(
   input  wire          clk,
   input  wire          rst_i,
   input  wire          out_valid_e_i,
   input  wire req_id_t out_id_e_i,
   input  wire          out_hit_e_i,
   input  wire line_t   out_line_e_i,
   input  wire          out_valid_o_i,
   input  wire req_id_t out_id_o_i,
   input  wire          out_hit_o_i,
   input  wire line_t   out_line_o_i,
   input  wire          res_ready_i,
   output logic         take_e_o,
   output logic         take_o_o,
   output logic         res_valid_o,
   output req_id_t      res_id_o,
   output logic         res_hit_o,
   output line_t        res_line_o
);

   logic ptr_q;
   logic sel;
   logic xfer;

   // Pointer decides when both banks hold a result
   assign sel = (out_valid_e_i && out_valid_o_i) ? ptr_q : out_valid_o_i;

   assign res_valid_o = sel ? out_valid_o_i : out_valid_e_i;
   assign res_id_o    = sel ? out_id_o_i    : out_id_e_i;
   assign res_hit_o   = sel ? out_hit_o_i   : out_hit_e_i;
   assign res_line_o  = sel ? out_line_o_i  : out_line_e_i;

   assign xfer     = res_valid_o && res_ready_i;
   assign take_e_o = xfer && !sel;
   assign take_o_o = xfer && sel;

   // A stall parks the pointer on the held choice
   always_ff @(posedge clk) begin
      if (rst_i) begin
         ptr_q <= 1'b0;
      end else if (res_valid_o) begin
         if (res_ready_i)
            ptr_q <= ~sel;
         else
            ptr_q <= sel;
      end
   end

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top
   import dcache_pkg::*;
(
   input  wire          clk,
   input  wire          rst_i,
   input  wire          rd_valid_i,
   input  wire paddr_t  rd_addr_i,
   input  wire req_id_t rd_id_i,
   output logic         rd_ready_o,
   input  wire          wb_valid_i,
   input  wire paddr_t  wb_addr_i,
   input  wire line_t   wb_line_i,
   output logic         wb_ready_o,
   output logic         res_valid_o,
   output req_id_t      res_id_o,
   output logic         res_hit_o,
   output line_t        res_line_o,
   input  wire          res_ready_i
);

   // Steer to queues
   logic    push_e, push_o;
   aq_op_t  push_op_e, push_op_o;
   paddr_t  push_addr_e, push_addr_o;
   req_id_t push_id_e, push_id_o;
   line_t   push_line_e, push_line_o;
   logic    credit_e, credit_o;

   // Queues to banks
   logic    head_valid_e, head_valid_o;
   aq_op_t  head_op_e, head_op_o;
   paddr_t  head_addr_e, head_addr_o;
   req_id_t head_id_e, head_id_o;
   line_t   head_line_e, head_line_o;
   logic    pop_e, pop_o;

   // Banks to merge
   logic    out_valid_e, out_valid_o;
   req_id_t out_id_e, out_id_o;
   logic    out_hit_e, out_hit_o;
   line_t   out_line_e, out_line_o;
   logic    take_e, take_o;

   access_steer steer (
      .clk(clk), .rst_i(rst_i),
      .rd_valid_i(rd_valid_i), .rd_addr_i(rd_addr_i), .rd_id_i(rd_id_i),
      .wb_valid_i(wb_valid_i), .wb_addr_i(wb_addr_i), .wb_line_i(wb_line_i),
      .credit_e_i(credit_e), .credit_o_i(credit_o),
      .rd_ready_o(rd_ready_o), .wb_ready_o(wb_ready_o),
      .push_e_o(push_e), .push_o_o(push_o),
      .push_op_e_o(push_op_e), .push_op_o_o(push_op_o),
      .push_addr_e_o(push_addr_e), .push_addr_o_o(push_addr_o),
      .push_id_e_o(push_id_e), .push_id_o_o(push_id_o),
      .push_line_e_o(push_line_e), .push_line_o_o(push_line_o)
   );

   access_queue aq_e (
      .clk(clk), .rst_i(rst_i),
      .push_i(push_e), .push_op_i(push_op_e), .push_addr_i(push_addr_e),
      .push_id_i(push_id_e), .push_line_i(push_line_e), .pop_i(pop_e),
      .head_valid_o(head_valid_e), .head_op_o(head_op_e), .head_addr_o(head_addr_e),
      .head_id_o(head_id_e), .head_line_o(head_line_e), .credit_o(credit_e)
   );

   access_queue aq_o (
      .clk(clk), .rst_i(rst_i),
      .push_i(push_o), .push_op_i(push_op_o), .push_addr_i(push_addr_o),
      .push_id_i(push_id_o), .push_line_i(push_line_o), .pop_i(pop_o),
      .head_valid_o(head_valid_o), .head_op_o(head_op_o), .head_addr_o(head_addr_o),
      .head_id_o(head_id_o), .head_line_o(head_line_o), .credit_o(credit_o)
   );

   cache_bank bank_e (
      .clk(clk), .rst_i(rst_i),
      .head_valid_i(head_valid_e), .head_op_i(head_op_e), .head_addr_i(head_addr_e),
      .head_id_i(head_id_e), .head_line_i(head_line_e), .take_i(take_e),
      .pop_o(pop_e), .out_valid_o(out_valid_e), .out_id_o(out_id_e),
      .out_hit_o(out_hit_e), .out_line_o(out_line_e)
   );

   cache_bank bank_o (
      .clk(clk), .rst_i(rst_i),
      .head_valid_i(head_valid_o), .head_op_i(head_op_o), .head_addr_i(head_addr_o),
      .head_id_i(head_id_o), .head_line_i(head_line_o), .take_i(take_o),
      .pop_o(pop_o), .out_valid_o(out_valid_o), .out_id_o(out_id_o),
      .out_hit_o(out_hit_o), .out_line_o(out_line_o)
   );

   result_merge merge (
      .clk(clk), .rst_i(rst_i),
      .out_valid_e_i(out_valid_e), .out_id_e_i(out_id_e),
      .out_hit_e_i(out_hit_e), .out_line_e_i(out_line_e),
      .out_valid_o_i(out_valid_o), .out_id_o_i(out_id_o),
      .out_hit_o_i(out_hit_o), .out_line_o_i(out_line_o),
      .res_ready_i(res_ready_i),
      .take_e_o(take_e), .take_o_o(take_o),
      .res_valid_o(res_valid_o), .res_id_o(res_id_o),
      .res_hit_o(res_hit_o), .res_line_o(res_line_o)
   );

endmodule

`default_nettype wire

//--- tests/dcache_sva.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_sva
   import dcache_pkg::*;
(
   input wire          clk,
   input wire          rst_i,
   input wire          rd_valid_i,
   input wire          rd_ready_o,
   input wire req_id_t rd_id_i,
   input wire          res_valid_o,
   input wire          res_ready_i,
   input wire req_id_t res_id_o,
   input wire          res_hit_o,
   input wire line_t   res_line_o
);

   localparam int IDS = 1 << $bits(req_id_t);

   int             open_cnt;
   logic [IDS-1:0] open_ids;
   logic           rd_fire;
   logic           res_fire;

   assign rd_fire  = rd_valid_i && rd_ready_o;
   assign res_fire = res_valid_o && res_ready_i;

   // Reads accepted but not yet returned
   always_ff @(posedge clk) begin
      if (rst_i) begin
         open_cnt <= 0;
         open_ids <= '0;
      end else begin
         open_cnt <= open_cnt + int'(rd_fire) - int'(res_fire);
         if (res_fire)
            open_ids[res_id_o] <= 1'b0;
         if (rd_fire)
            open_ids[rd_id_i] <= 1'b1;
      end
   end

   stall_hold: assert property (@(posedge clk) disable iff (rst_i)
      res_valid_o && !res_ready_i |=>
         res_valid_o && $stable(res_id_o) && $stable(res_hit_o) && $stable(res_line_o))
      else $error("Result port changed while stalled");

   reset_quiet: assert property (@(posedge clk) rst_i |=> !res_valid_o)
      else $error("res_valid_o high right after reset");

   known_id: assert property (@(posedge clk) disable iff (rst_i)
      res_fire |-> (open_cnt > 0) && open_ids[res_id_o])
      else $error("Result delivered for an ID with no open read");

endmodule

bind dcache_top dcache_sva sva_chk (
   .clk(clk), .rst_i(rst_i),
   .rd_valid_i(rd_valid_i), .rd_ready_o(rd_ready_o), .rd_id_i(rd_id_i),
   .res_valid_o(res_valid_o), .res_ready_i(res_ready_i), .res_id_o(res_id_o),
   .res_hit_o(res_hit_o), .res_line_o(res_line_o)
);

`default_nettype wire

//--- tests/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "dcache_settings.svh"

module dcache_tb
   import dcache_pkg::*;
();

   localparam int REQ_TOTAL   = 8 + 5 + 4 + 12 + 200;
   localparam int CYCLE_LIMIT = 4 * REQ_TOTAL + 200;
   localparam int HOLD_MAX    = 2 * `DC_AQ_DEPTH + 2;
   localparam int IDS         = 1 << $bits(req_id_t);

   logic    clk;
   logic    rst_i;
   logic    rd_valid_i;
   paddr_t  rd_addr_i;
   req_id_t rd_id_i;
   logic    rd_ready_o;
   logic    wb_valid_i;
   paddr_t  wb_addr_i;
   line_t   wb_line_i;
   logic    wb_ready_o;
   logic    res_valid_o;
   req_id_t res_id_o;
   logic    res_hit_o;
   line_t   res_line_o;
   logic    res_ready_i;

   // Reference cache, one slot per bank and index
   logic    m_valid [32];
   tag_t    m_tag   [32];
   line_t   m_line  [32];

   // Expected results of outstanding reads, keyed by ID
   logic    e_pend [IDS];
   logic    e_hit  [IDS];
   line_t   e_line [IDS];
   logic    e_bank [IDS];
   req_id_t order_e[$];
   req_id_t order_o[$];

   int          outstanding = 0;
   int          results = 0;
   int          checks = 0;
   int          errors = 0;
   int          cycles = 0;
   req_id_t     next_id = '0;
   logic [31:0] rng;

   dcache_top UUT (
      .clk(clk), .rst_i(rst_i),
      .rd_valid_i(rd_valid_i), .rd_addr_i(rd_addr_i), .rd_id_i(rd_id_i),
      .rd_ready_o(rd_ready_o),
      .wb_valid_i(wb_valid_i), .wb_addr_i(wb_addr_i), .wb_line_i(wb_line_i),
      .wb_ready_o(wb_ready_o),
      .res_valid_o(res_valid_o), .res_id_o(res_id_o), .res_hit_o(res_hit_o),
      .res_line_o(res_line_o), .res_ready_i(res_ready_i)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // Offset 3:0, bank 4, index 8:5, tag 14:9
   function automatic logic [4:0] slot_of(paddr_t a);
      return a[8:4];
   endfunction

   function automatic tag_t tag_of(paddr_t a);
      return a[14:9];
   endfunction

   function automatic paddr_t make_addr(tag_t t, index_t i, logic b, logic [3:0] off);
      return {t, i, b, off};
   endfunction

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng = x;
      return x;
   endfunction

   function automatic line_t rand_line();
      line_t l;
      for (int i = 0; i < 4; i++)
         l[i*32 +: 32] = next_rand();
      return l;
   endfunction

   function automatic req_id_t alloc_id();
      while (e_pend[next_id])
         next_id++;
      alloc_id = next_id;
      next_id++;
   endfunction

   task automatic check_hit(string name, logic exp, logic got);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: %s expected 0x%h got 0x%h", name, exp, got);
      end
   endtask

   task automatic check_line(string name, line_t exp, line_t got);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: %s expected 0x%h got 0x%h", name, exp, got);
      end
   endtask

   task automatic check_id(string name, req_id_t exp, req_id_t got);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: %s expected 0x%h got 0x%h", name, exp, got);
      end
   endtask

   // Model follows acceptance order, which matches per-bank completion order
   always @(posedge clk) begin
      req_id_t    rid;
      req_id_t    front;
      logic [4:0] s;
      if (!rst_i) begin
         if (res_valid_o && res_ready_i) begin
            rid = res_id_o;
            if (!e_pend[rid]) begin
               errors++;
               $display("Result for ID 0x%h arrived with no outstanding read", rid);
            end else begin
               front = e_bank[rid] ? order_o.pop_front() : order_e.pop_front();
               check_id("res_id_o", front, rid);
               check_hit("res_hit_o", e_hit[rid], res_hit_o);
               if (e_hit[rid])
                  check_line("res_line_o", e_line[rid], res_line_o);
               e_pend[rid] = 1'b0;
               outstanding--;
               results++;
            end
         end
         if (rd_valid_i && rd_ready_o) begin
            s = slot_of(rd_addr_i);
            e_pend[rd_id_i] = 1'b1;
            e_bank[rd_id_i] = rd_addr_i[4];
            e_hit[rd_id_i]  = m_valid[s] && (m_tag[s] == tag_of(rd_addr_i));
            e_line[rd_id_i] = m_line[s];
            if (rd_addr_i[4])
               order_o.push_back(rd_id_i);
            else
               order_e.push_back(rd_id_i);
            outstanding++;
         end
         if (wb_valid_i && wb_ready_o) begin
            s = slot_of(wb_addr_i);
            m_valid[s] = 1'b1;
            m_tag[s]   = tag_of(wb_addr_i);
            m_line[s]  = wb_line_i;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, results still missing", cycles);
         $display("Test failed");
         $finish;
      end
   end

   task automatic send_read(paddr_t a);
      rd_addr_i  = a;
      rd_id_i    = alloc_id();
      rd_valid_i = 1'b1;
      do @(posedge clk); while (!rd_ready_o);
      @(negedge clk);
      rd_valid_i = 1'b0;
   endtask

   task automatic send_write(paddr_t a, line_t l);
      wb_addr_i  = a;
      wb_line_i  = l;
      wb_valid_i = 1'b1;
      do @(posedge clk); while (!wb_ready_o);
      @(negedge clk);
      wb_valid_i = 1'b0;
   endtask

   task automatic offer_read(paddr_t a, int limit, output logic taken);
      int n;
      n          = 0;
      taken      = 1'b0;
      rd_addr_i  = a;
      rd_id_i    = alloc_id();
      rd_valid_i = 1'b1;
      while (!taken && n < limit) begin
         @(posedge clk);
         taken = rd_ready_o;
         n++;
      end
      @(negedge clk);
      rd_valid_i = 1'b0;
   endtask

   task automatic wait_drain();
      while (outstanding != 0)
         @(negedge clk);
   endtask

   task automatic end_test(string name, int err0);
      $display("%-14s done, %0d errors", name, errors - err0);
   endtask

   task automatic test_reset_miss();
      int err0;
      err0 = errors;
      if (!rd_ready_o || !wb_ready_o || res_valid_o) begin
         errors++;
         $display("Ready or result valid outputs are not in their reset state");
      end
      for (int i = 0; i < 8; i++)
         send_read(make_addr(tag_t'(i + 1), index_t'(i), i[0], 4'(i)));
      wait_drain();
      end_test("reset_miss", err0);
   endtask

   task automatic test_write_read();
      int     err0;
      paddr_t a;
      err0 = errors;
      a    = make_addr(6'h12, 4'h3, 1'b0, 4'h0);
      send_write(a, rand_line());
      send_read(a);
      send_read(a | 15'h5);
      send_read(a | 15'ha);
      send_read(a | 15'hf);
      wait_drain();
      end_test("write_read", err0);
   endtask

   task automatic test_evict();
      int     err0;
      paddr_t a;
      paddr_t b;
      err0 = errors;
      a    = make_addr(6'h03, 4'h6, 1'b1, 4'h0);
      b    = make_addr(6'h21, 4'h6, 1'b1, 4'h8);
      send_write(a, rand_line());
      send_write(b, rand_line());
      send_read(a);
      send_read(b);
      wait_drain();
      end_test("evict", err0);
   endtask

   task automatic test_backpressure();
      int   err0;
      int   n_acc;
      int   res0;
      int   i;
      logic taken;
      err0        = errors;
      res0        = results;
      n_acc       = 0;
      i           = 0;
      taken       = 1'b1;
      res_ready_i = 1'b0;
      while (taken && i < 12) begin
         offer_read(make_addr(6'h12, index_t'(i >> 1), i[0], 4'h0), 4, taken);
         if (taken)
            n_acc++;
         i++;
      end
      if (taken) begin
         errors++;
         $display("rd_ready_o never dropped with the result port stalled");
      end
      if (n_acc > HOLD_MAX) begin
         errors++;
         $display("Accepted %0d reads while stalled, room for only %0d", n_acc, HOLD_MAX);
      end
      res_ready_i = 1'b1;
      wait_drain();
      if (results - res0 != n_acc) begin
         errors++;
         $display("Got %0d results for %0d accepted reads", results - res0, n_acc);
      end
      end_test("backpressure", err0);
   endtask

   task automatic test_random();
      int          err0;
      int          n_req;
      logic        rd_took;
      logic        wb_took;
      logic [31:0] r;
      err0    = errors;
      n_req   = 0;
      rd_took = 1'b0;
      wb_took = 1'b0;
      while (n_req < 200 || rd_valid_i || wb_valid_i) begin
         @(negedge clk);
         if (rd_took)
            rd_valid_i = 1'b0;
         if (wb_took)
            wb_valid_i = 1'b0;
         r           = next_rand();
         res_ready_i = r[0];
         if (!rd_valid_i && n_req < 200 && r[1]) begin
            r          = next_rand();
            rd_addr_i  = make_addr(r[0] ? 6'h05 : 6'h2a, index_t'(r[3:1]), r[4], r[8:5]);
            rd_id_i    = alloc_id();
            rd_valid_i = 1'b1;
            n_req++;
         end
         if (!wb_valid_i && n_req < 200 && r[2]) begin
            r          = next_rand();
            wb_addr_i  = make_addr(r[0] ? 6'h05 : 6'h2a, index_t'(r[3:1]), r[4], r[8:5]);
            wb_line_i  = rand_line();
            wb_valid_i = 1'b1;
            n_req++;
         end
         @(posedge clk);
         rd_took = rd_valid_i && rd_ready_o;
         wb_took = wb_valid_i && wb_ready_o;
      end
      @(negedge clk);
      res_ready_i = 1'b1;
      wait_drain();
      end_test("random", err0);
   endtask

   initial begin
      rng         = 32'h7099;
      rst_i       = 1'b1;
      rd_valid_i  = 1'b0;
      rd_addr_i   = '0;
      rd_id_i     = '0;
      wb_valid_i  = 1'b0;
      wb_addr_i   = '0;
      wb_line_i   = '0;
      res_ready_i = 1'b1;
      for (int i = 0; i < 32; i++)
         m_valid[i] = 1'b0;
      for (int i = 0; i < IDS; i++)
         e_pend[i] = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_i = 1'b0;

      test_reset_miss();
      test_write_read();
      test_evict();
      test_backpressure();
      test_random();

      $display("Checks %0d, results %0d, errors %0d", checks, results, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/access_steer.sv
hdl/access_queue.sv
hdl/cache_bank.sv
hdl/result_merge.sv
hdl/dcache_top.sv
tests/dcache_sva.sv
tests/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dcache_pkg.sv
      - hdl/access_steer.sv
      - hdl/access_queue.sv
      - hdl/cache_bank.sv
      - hdl/result_merge.sv
      - hdl/dcache_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/dcache_sva.sv
      - tests/dcache_tb.sv
